//--- src/heapCfg.svh
//------------------------------
// Array heap sizes
// Array count, array length and element width
//------------------------------
`ifndef HEAP_CFG_SVH
`define HEAP_CFG_SVH

// Widths ----------------------
`define HEAP_ARRAY_BITS 3                              // Bits in an array number
`define HEAP_INDEX_BITS 2                              // Bits in an element index
`define HEAP_DATA_BITS 12                              // Bits in an element

// Derived counts --------------
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)            // Arrays in the heap
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)            // Elements per array

`endif

//--- src/heapPkg.sv
//------------------------------
// Array heap types
// Actions, errors and the payloads between stages
//------------------------------
`default_nettype none

`include "heapCfg.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNumT;      // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;         // Element index
  typedef logic [`HEAP_INDEX_BITS:0] sizeT;            // Array size, up to full length
  typedef logic [`HEAP_DATA_BITS-1:0] dataT;           // Element value

  // Action codes as seen on the bus
  typedef enum logic [7:0] {
    actionReset    = 8'd1,
    actionWrite    = 8'd2,
    actionRead     = 8'd3,
    actionSize     = 8'd4,
    actionPush     = 8'd14,
    actionPop      = 8'd15,
    actionAlloc    = 8'd18,
    actionFree     = 8'd19,
    actionAdd      = 8'd20,
    actionSubtract = 8'd22
  } heapActionT;

  typedef enum logic [2:0] {
    errorNone, errorNotAllocated, errorFreed, errorOutOfBounds,
    errorFull, errorEmpty, errorOutOfMemory, errorBadAction
  } heapErrorT;

  typedef enum logic [1:0] {checkNone, checkWriteable, checkReadable} checkClassT;

  typedef enum logic [2:0] {
    opNone, opStore, opLoad, opAdd, opSubtract, opReturnSize, opReturnArray
  } elementOpT;

  typedef enum logic [2:0] {dirNone, dirReset, dirAlloc, dirFree, dirPush, dirPop} dirOpT;

  // Stage payloads --------------
  typedef struct packed {
    heapActionT action;
    arrayNumT   array;
    indexT      index;
    dataT       data;
  } heapRequestT;

  typedef struct packed {
    logic        valid;
    heapRequestT request;
    checkClassT  checkClass;                           // Legality checks to apply
    elementOpT   elementOp;                            // Work for the element store
    dirOpT       dirOp;                                // Work for the directory
    logic        badAction;                            // Unknown action code
  } heapDecodedT;

  typedef struct packed {
    logic      valid;
    elementOpT elementOp;
    arrayNumT  array;                                  // Element address, array part
    indexT     slot;                                   // Element address, slot part
    dataT      data;                                   // Operand from the request
    dataT      value;                                  // Size or array number to return
    heapErrorT error;
  } heapAccessT;

  typedef struct packed {
    dataT      data;
    heapErrorT error;
  } heapResponseT;

endpackage

`default_nettype wire

//--- src/heapDecoder.sv
//------------------------------
// Array heap decode stage
// Registers requests and classifies the action
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module heapDecoder (
  input  wire                 clock,
  input  wire                 reset,
  input  heapPkg::heapRequestT request,
  input  wire                 requestValid,
  output heapPkg::heapDecodedT decoded
);
  import heapPkg::*;

  heapDecodedT classified;                             // Decode of the incoming request

  always_comb begin
    classified            = '0;
    classified.valid      = 1'b1;
    classified.request    = request;
    classified.checkClass = checkNone;
    classified.elementOp  = opNone;
    classified.dirOp      = dirNone;
    case (request.action)
      actionReset:    classified.dirOp = dirReset;
      actionWrite:    {classified.checkClass, classified.elementOp} = {checkWriteable, opStore};
      actionRead:     {classified.checkClass, classified.elementOp} = {checkReadable, opLoad};
      actionSize:     {classified.checkClass, classified.elementOp} = {checkWriteable, opReturnSize};
      actionPush: begin
        classified.checkClass = checkWriteable;
        classified.elementOp  = opStore;               // Stored at the old size
        classified.dirOp      = dirPush;
      end
      actionPop: begin
        classified.checkClass = checkWriteable;
        classified.elementOp  = opLoad;                // Loaded from the new size
        classified.dirOp      = dirPop;
      end
      actionAlloc:    {classified.elementOp, classified.dirOp} = {opReturnArray, dirAlloc};
      actionFree:     {classified.checkClass, classified.dirOp} = {checkWriteable, dirFree};
      actionAdd:      {classified.checkClass, classified.elementOp} = {checkReadable, opAdd};
      actionSubtract: {classified.checkClass, classified.elementOp} = {checkReadable, opSubtract};
      default:        classified.badAction = 1'b1;
    endcase
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      decoded <= '0;
    end else if (requestValid) begin
      decoded <= classified;
    end else begin
      decoded.valid <= 1'b0;                           // Hold payload, drop the strobe
    end
  end

endmodule

`default_nettype wire

//--- src/arrayDirectory.sv
//------------------------------
// Array heap directory stage
// Allocation, free stack, sizes and legality checks
//------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "heapCfg.svh"

module arrayDirectory (
  input  wire                 clock,
  input  wire                 reset,
  input  heapPkg::heapDecodedT decoded,
  output heapPkg::heapAccessT  access
);
  import heapPkg::*;

  localparam sizeT fullSize = sizeT'(`HEAP_LENGTH);
  localparam logic [`HEAP_ARRAY_BITS:0] allArrays = (`HEAP_ARRAY_BITS+1)'(`HEAP_ARRAYS);

  // Directory state -------------
  logic [`HEAP_ARRAYS-1:0]   allocated;                // Live arrays
  logic [`HEAP_ARRAY_BITS:0] usedCount;                // Arrays ever handed out
  logic [`HEAP_ARRAY_BITS:0] freeTop;                  // Entries on the free stack
  arrayNumT                  freeStack [`HEAP_ARRAYS];
  sizeT                      sizes [`HEAP_ARRAYS];

  heapRequestT request;
  sizeT        sizeNow;
  logic        neverUsed;
  logic        outOfMemory;
  arrayNumT    popIndex;
  arrayNumT    allocNumber;
  arrayNumT    targetArray;
  heapErrorT   error;
  logic        commit;
  indexT       slot;
  dataT        returnValue;

  assign request     = decoded.request;
  assign sizeNow     = sizes[request.array];
  assign neverUsed   = {1'b0, request.array} >= usedCount;
  assign outOfMemory = (freeTop == '0) && (usedCount == allArrays);
  assign popIndex    = freeTop[`HEAP_ARRAY_BITS-1:0] - 1'b1;
  assign allocNumber = (freeTop != '0) ? freeStack[popIndex]   // Last freed comes back first
                                       : usedCount[`HEAP_ARRAY_BITS-1:0];
  assign targetArray = (decoded.dirOp == dirAlloc) ? allocNumber : request.array;
  assign commit      = decoded.valid && (error == errorNone);

  // Checks in priority order
  always_comb begin
    error = errorNone;
    if (decoded.badAction) begin
      error = errorBadAction;
    end else if (decoded.checkClass != checkNone && neverUsed) begin
      error = errorNotAllocated;
    end else if (decoded.checkClass != checkNone && !allocated[request.array]) begin
      error = errorFreed;
    end else if (decoded.checkClass == checkReadable && {1'b0, request.index} >= sizeNow) begin
      error = errorOutOfBounds;
    end else if (decoded.dirOp == dirPush && sizeNow == fullSize) begin
      error = errorFull;
    end else if (decoded.dirOp == dirPop && sizeNow == '0) begin
      error = errorEmpty;
    end else if (decoded.dirOp == dirAlloc && outOfMemory) begin
      error = errorOutOfMemory;
    end
  end

  always_comb begin
    case (decoded.dirOp)
      dirPush: slot = sizeNow[`HEAP_INDEX_BITS-1:0];            // Old size
      dirPop:  slot = sizeNow[`HEAP_INDEX_BITS-1:0] - 1'b1;     // New size
      default: slot = request.index;
    endcase
    case (decoded.elementOp)
      opReturnSize:  returnValue = dataT'(sizeNow);
      opReturnArray: returnValue = dataT'(allocNumber);
      default:       returnValue = '0;
    endcase
  end

  // Control state and stage output
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated <= '0;
      usedCount <= '0;
      freeTop   <= '0;
      access    <= '0;
    end else begin
      access.valid     <= decoded.valid;
      access.elementOp <= decoded.elementOp;
      access.array     <= targetArray;
      access.slot      <= slot;
      access.data      <= request.data;
      access.value     <= returnValue;
      access.error     <= error;
      if (commit) begin
        case (decoded.dirOp)
          dirReset: begin
            allocated <= '0;
            usedCount <= '0;
            freeTop   <= '0;
          end
          dirAlloc: begin
            allocated[allocNumber] <= 1'b1;
            if (freeTop != '0) begin
              freeTop <= freeTop - 1'b1;
            end else begin
              usedCount <= usedCount + 1'b1;
            end
          end
          dirFree: begin
            allocated[request.array] <= 1'b0;
            freeTop                  <= freeTop + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Sizes and free stack storage
  always_ff @(posedge clock) begin
    if (commit) begin
      case (decoded.dirOp)
        dirAlloc: sizes[allocNumber] <= '0;
        dirFree:  freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= request.array;
        dirPush:  sizes[request.array] <= sizeNow + 1'b1;
        dirPop:   sizes[request.array] <= sizeNow - 1'b1;
        default: begin
          if (decoded.elementOp == opStore && {1'b0, request.index} >= sizeNow) begin
            sizes[request.array] <= {1'b0, request.index} + 1'b1;  // Write grows the array
          end
        end
      endcase
    end
  end

  // Free stack holds no more than the arrays ever handed out
  stackBound: assert property (@(posedge clock) disable iff (!reset)
    freeTop <= usedCount && usedCount <= allArrays)
    else $error("free stack overflow");

  sizeBound: assert property (@(posedge clock) disable iff (!reset)
    decoded.valid && allocated[request.array] |-> sizeNow <= fullSize)
    else $error("array size beyond length");

endmodule

`default_nettype wire

//--- src/elementStore.sv
//------------------------------
// Array heap element stage
// Element memory, arithmetic and the response register
//------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "heapCfg.svh"

module elementStore (
  input  wire                  clock,
  input  wire                  reset,
  input  heapPkg::heapAccessT   access,
  output heapPkg::heapResponseT response,
  output logic                 responseValid
);
  import heapPkg::*;

  localparam int words = `HEAP_ARRAYS * `HEAP_LENGTH;

  dataT elements [words];                              // One block per array

  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0] address;
  dataT oldValue;
  dataT newValue;
  dataT result;
  logic modifies;
  logic writeEnable;

  assign address     = {access.array, access.slot};
  assign oldValue    = elements[address];
  assign writeEnable = modifies && access.valid && (access.error == errorNone);

  // Read, modify and pick the result
  always_comb begin
    newValue = oldValue;
    result   = '0;
    modifies = 1'b0;
    case (access.elementOp)
      opStore: begin
        newValue = access.data;
        result   = access.data;
        modifies = 1'b1;
      end
      opLoad:  result = oldValue;
      opAdd: begin
        newValue = oldValue + access.data;             // Wraps at data width
        result   = newValue;
        modifies = 1'b1;
      end
      opSubtract: begin
        newValue = oldValue - access.data;
        result   = newValue;
        modifies = 1'b1;
      end
      opReturnSize, opReturnArray: result = access.value;  // From the directory
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      elements[address] <= newValue;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      responseValid <= 1'b0;
      response      <= '0;
    end else begin
      responseValid  <= access.valid;
      response.data  <= (access.error == errorNone) ? result : '0;  // Failures return 0
      response.error <= access.error;
    end
  end

  // A failed request leaves its element untouched
  noWriteOnError: assert property (@(posedge clock) disable iff (!reset)
    access.valid && access.error != errorNone |=> elements[$past(address)] == $past(oldValue))
    else $error("element changed by a failed request");

endmodule

`default_nettype wire

//--- src/arrayHeap.sv
//------------------------------
// Array heap top level
// Decode, directory and element stages in a row
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module arrayHeap (
  input  wire                  clock,
  input  wire                  reset,
  input  heapPkg::heapRequestT  request,
  input  wire                  requestValid,
  output heapPkg::heapResponseT response,
  output logic                 responseValid
);
  import heapPkg::*;

  heapDecodedT decoded;                                // Stage 1 to stage 2
  heapAccessT  access;                                 // Stage 2 to stage 3

  heapDecoder decode0 (
    .clock        (clock),
    .reset        (reset),
    .request      (request),
    .requestValid (requestValid),
    .decoded      (decoded)
  );

  arrayDirectory directory0 (
    .clock   (clock),
    .reset   (reset),
    .decoded (decoded),
    .access  (access)
  );

  elementStore store0 (
    .clock         (clock),
    .reset         (reset),
    .access        (access),
    .response      (response),
    .responseValid (responseValid)
  );

endmodule

`default_nettype wire

//--- test/heapModel.svh
//------------------------------
// Array heap reference model
// Predicts the response of each request in order
//------------------------------
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

bit   liveArray [`HEAP_ARRAYS];                        // Allocated right now
int   arraySize [`HEAP_ARRAYS];
int   freshCount;                                      // Numbers handed out since reset
int   freedStack [$];                                  // Top at the back
dataT heapMemory [`HEAP_ARRAYS][`HEAP_LENGTH];         // Survives Reset and Free

task automatic clearDirectory();
  freshCount = 0;
  freedStack.delete();
  foreach (liveArray[n]) begin
    liveArray[n] = 1'b0;
    arraySize[n] = 0;
  end
endtask

// Allocation state of an array named by a request
function automatic heapErrorT usageError(input int number);
  if (number >= freshCount) return errorNotAllocated;
  if (!liveArray[number]) return errorFreed;
  return errorNone;
endfunction

task automatic predictResponse(input heapRequestT req, output heapResponseT expected);
  int        a;
  int        i;
  heapErrorT err;
  dataT      result;
  a      = req.array;
  i      = req.index;
  err    = errorNone;
  result = '0;
  case (req.action)
    actionReset: clearDirectory();
    actionAlloc: begin
      if (freedStack.size() != 0) a = freedStack.pop_back();  // Last freed first
      else if (freshCount < `HEAP_ARRAYS) a = freshCount++;
      else err = errorOutOfMemory;
      if (err == errorNone) begin
        liveArray[a] = 1'b1;
        arraySize[a] = 0;
        result       = dataT'(a);
      end
    end
    actionFree: begin
      err = usageError(a);
      if (err == errorNone) begin
        liveArray[a] = 1'b0;
        freedStack.push_back(a);
      end
    end
    actionWrite: begin
      err = usageError(a);
      if (err == errorNone) begin
        heapMemory[a][i] = req.data;
        if (i >= arraySize[a]) arraySize[a] = i + 1;
        result = req.data;
      end
    end
    actionSize: begin
      err    = usageError(a);
      result = dataT'(arraySize[a]);
    end
    actionPush: begin
      err = usageError(a);
      if (err == errorNone && arraySize[a] == `HEAP_LENGTH) err = errorFull;
      if (err == errorNone) begin
        heapMemory[a][arraySize[a]] = req.data;
        arraySize[a]++;
        result = req.data;
      end
    end
    actionPop: begin
      err = usageError(a);
      if (err == errorNone && arraySize[a] == 0) err = errorEmpty;
      if (err == errorNone) begin
        arraySize[a]--;
        result = heapMemory[a][arraySize[a]];
      end
    end
    actionRead, actionAdd, actionSubtract: begin
      err = usageError(a);
      if (err == errorNone && i >= arraySize[a]) err = errorOutOfBounds;
      if (err == errorNone) begin
        if (req.action == actionAdd) heapMemory[a][i] = heapMemory[a][i] + req.data;
        if (req.action == actionSubtract) heapMemory[a][i] = heapMemory[a][i] - req.data;
        result = heapMemory[a][i];
      end
    end
    default: err = errorBadAction;
  endcase
  expected.error = err;
  expected.data  = (err == errorNone) ? result : '0;
endtask

`endif

//--- test/arrayHeapTb.sv
//------------------------------
// Array heap testbench
// Random requests checked against a reference model
//------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "heapCfg.svh"

module arrayHeapTb;
  import heapPkg::*;

  `include "heapModel.svh"

  localparam int randomCount = 600;
  localparam int cycleLimit  = 3000;                   // 643 requests at 4 cycles, reset, drain

  logic         clock;
  logic         reset;
  heapRequestT  request;
  logic         requestValid;
  heapResponseT response;
  logic         responseValid;

  heapResponseT expectedQueue [$];
  string        nameQueue [$];
  int           seed;
  int           codeErrors;
  int           dataErrors;
  int           missingCount;
  int           extraCount;
  int           cycleCount;

  arrayHeap dut0 (
    .clock         (clock),
    .reset         (reset),
    .request       (request),
    .requestValid  (requestValid),
    .response      (response),
    .responseValid (responseValid)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic int unsigned randomBelow(input int unsigned limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  function automatic heapActionT evenAction();
    int unsigned pick;
    pick = randomBelow(40);
    if (pick < 2) return actionReset;
    if (pick < 4) return heapActionT'(8'(100 + randomBelow(156)));  // Unknown code
    case ((pick - 4) / 4)
      0:       return actionWrite;
      1:       return actionRead;
      2:       return actionSize;
      3:       return actionPush;
      4:       return actionPop;
      5:       return actionAlloc;
      6:       return actionFree;
      7:       return actionAdd;
      default: return actionSubtract;
    endcase
  endfunction

  function automatic heapRequestT randomRequest(input bit early);
    heapRequestT req;
    int unsigned pick;
    pick      = randomBelow(100);
    req.array = arrayNumT'(randomBelow(`HEAP_ARRAYS));
    req.index = indexT'(randomBelow(`HEAP_LENGTH));
    req.data  = dataT'(randomBelow(1 << `HEAP_DATA_BITS));
    if (early && pick < 70) begin                      // Build up arrays first
      req.action = (pick < 25) ? actionAlloc : (pick < 50) ? actionPush : actionWrite;
    end else begin
      req.action = evenAction();
    end
    return req;
  endfunction

  task automatic sendRequest(input heapRequestT req, input string phase);
    heapResponseT expected;
    @(posedge clock);
    request      <= req;
    requestValid <= 1'b1;
    predictResponse(req, expected);
    expectedQueue.push_back(expected);
    nameQueue.push_back($sformatf("%s action %0d", phase, req.action));
  endtask

  task automatic idleCycles(input int unsigned count);
    repeat (count) begin
      @(posedge clock);
      requestValid <= 1'b0;
    end
  endtask

  task automatic checkResponse();
    heapResponseT expected;
    string        name;
    assert (expectedQueue.size() != 0) else begin
      $display("a response arrived while no request was outstanding");
      extraCount++;
    end
    if (expectedQueue.size() != 0) begin
      expected = expectedQueue.pop_front();
      name     = nameQueue.pop_front();
      assert (response.error == expected.error) else begin
        $display("error %s: expected %s, actual %s", name, expected.error.name(),
                 response.error.name());
        codeErrors++;
      end
      assert (response.data == expected.data) else begin
        $display("error %s: expected %0d, actual %0d", name, expected.data, response.data);
        dataErrors++;
      end
    end
  endtask

  // Checking and watchdog ------
  always @(negedge clock) begin
    if (reset && responseValid) checkResponse();       // Outputs settled mid-cycle
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Stimulus -------------------
  initial begin
    int drain;
    seed         = 60;
    codeErrors   = 0;
    dataErrors   = 0;
    missingCount = 0;
    extraCount   = 0;
    cycleCount   = 0;
    reset        = 1'b0;
    requestValid = 1'b0;
    request      = '0;
    clearDirectory();
    repeat (8) @(posedge clock);
    reset <= 1'b1;
    repeat (`HEAP_ARRAYS + 1) sendRequest('{actionAlloc, 0, 0, 0}, "fill");  // Last one fails
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin       // Every element gets a known value
      for (int i = 0; i < `HEAP_LENGTH; i++) begin
        sendRequest('{actionWrite, arrayNumT'(a), indexT'(i),
                      dataT'(randomBelow(1 << `HEAP_DATA_BITS))}, "preload");
      end
    end
    sendRequest('{actionReset, 0, 0, 0}, "reset");
    sendRequest('{actionAlloc, 0, 0, 0}, "after reset");
    for (int n = 0; n < randomCount; n++) begin
      sendRequest(randomRequest(n < randomCount / 3), "random");
      idleCycles(randomBelow(4));
    end
    idleCycles(1);
    drain = 0;
    while (expectedQueue.size() != 0 && drain < 20) begin
      @(posedge clock);
      drain++;
    end
    missingCount = expectedQueue.size();
    assert (missingCount == 0) else $display("%0d responses never arrived", missingCount);
    $display("errors: code %0d, data %0d, missing %0d, unexpected %0d",
             codeErrors, dataErrors, missingCount, extraCount);
    if (codeErrors + dataErrors + missingCount + extraCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
+incdir+test
src/heapPkg.sv
src/heapDecoder.sv
src/arrayDirectory.sv
src/elementStore.sv
src/arrayHeap.sv
test/arrayHeapTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the array heap testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module arrayHeapTb; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/VarrayHeapTb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
